//--- bench/mem_ref_model.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// address window shared by all memory operations
localparam int          WIN_WORDS = 8;
localparam logic [31:0] WIN_BASE  = 32'h0000_0400;

// shadow copy of the window, one entry per byte
logic [7:0] shadow_mem [0:4*WIN_WORDS-1];
// expected results in request order
mem_res_t   expected_q [$];

// store rules applied byte by byte to the shadow memory
task automatic apply_store(input ex_req_t req);
    int unsigned rel;
    int          base;
    int          off;
    logic [31:0] rt;
    rel  = req.alu_res - WIN_BASE;
    base = int'(rel & 32'hFFFF_FFFC);
    off  = int'(rel & 32'h3);
    rt   = req.rt_data;
    case (req.ls_sel)
        `LS_SEL_SB: shadow_mem[base + off] = rt[7:0];
        `LS_SEL_SH: begin
            // odd half offsets leave memory alone
            if (off % 2 == 0) begin
                shadow_mem[base + off]     = rt[7:0];
                shadow_mem[base + off + 1] = rt[15:8];
            end
        end
        `LS_SEL_SW: begin
            for (int j = 0; j < 4; j++) begin
                shadow_mem[base + j] = rt[8*j +: 8];
            end
        end
        // bytes 0..off take the top of rt
        `LS_SEL_SWL: begin
            for (int j = 0; j <= off; j++) begin
                shadow_mem[base + j] = rt[8*(j + 3 - off) +: 8];
            end
        end
        // bytes off..3 take the bottom of rt
        `LS_SEL_SWR: begin
            for (int j = off; j < 4; j++) begin
                shadow_mem[base + j] = rt[8*(j - off) +: 8];
            end
        end
        default: ;
    endcase
endtask

// load rules read from the shadow memory, zero for anything else
function automatic logic [31:0] load_value(input ex_req_t req);
    int unsigned rel;
    int          base;
    int          off;
    logic [7:0]  m [4];
    logic [15:0] half;
    logic [31:0] res;
    rel  = req.alu_res - WIN_BASE;
    base = int'(rel & 32'hFFFF_FFFC);
    off  = int'(rel & 32'h3);
    for (int j = 0; j < 4; j++) begin
        m[j] = shadow_mem[base + j];
    end
    half = (off < 3) ? {m[off + 1], m[off]} : 16'h0;
    res  = 32'h0;
    case (req.ls_sel)
        `LS_SEL_LB:  res = {{24{m[off][7]}}, m[off]};
        `LS_SEL_LBU: res = {24'h0, m[off]};
        `LS_SEL_LH:  res = (off % 2 == 0) ? {{16{half[15]}}, half} : 32'h0;
        `LS_SEL_LHU: res = (off % 2 == 0) ? {16'h0, half} : 32'h0;
        `LS_SEL_LW:  res = {m[3], m[2], m[1], m[0]};
        `LS_SEL_LWL: begin
            // memory bytes 0..off into the top lanes
            res = req.rt_data;
            for (int j = 0; j <= off; j++) begin
                res[8*(3 - off + j) +: 8] = m[j];
            end
        end
        `LS_SEL_LWR: begin
            // memory bytes off..3 into the bottom lanes
            res = req.rt_data;
            for (int j = off; j < 4; j++) begin
                res[8*(j - off) +: 8] = m[j];
            end
        end
        default: res = 32'h0;
    endcase
    return res;
endfunction

// loads see memory before this op, stores update it afterwards
task automatic predict_result(input ex_req_t req);
    mem_res_t e;
    e.pc         = req.pc;
    e.alu_res    = req.alu_res;
    e.w_reg_ena  = req.w_reg_ena;
    e.w_reg_dst  = req.w_reg_dst;
    e.wb_reg_sel = req.wb_reg_sel;
    e.w_hilo_ena = req.w_hilo_ena;
    e.hi_res     = req.hi_res;
    e.lo_res     = req.lo_res;
    e.r_data     = 32'h0;
    if (req.ls_ena) begin
        e.r_data = load_value(req);
        apply_store(req);
    end
    expected_q.push_back(e);
endtask

`endif

//--- bench/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_stage
    import lsu_pkg::*;
;

    `include "mem_ref_model.svh"

    localparam int SEED     = 20096;
    localparam int NUM_OPS  = 3000;
    // window fill, random ops and two drain cycles
    localparam int STIM_CYC = WIN_WORDS + NUM_OPS + 2;
    localparam int WATCHDOG_NS = 2 * STIM_CYC * 10 + 3 * 10;

    logic     clk;
    logic     rst_n;
    ex_req_t  ex_req;
    mem_res_t mem_res;

    int checks;
    int errors;

    mem_stage_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_req  (ex_req),
        .mem_res (mem_res)
    );

    // 10 ns period
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // every field of one write-back bundle
    task automatic compare_result(input mem_res_t got, input mem_res_t exp);
        check_value("mem_res.pc", got.pc, exp.pc);
        check_value("mem_res.alu_res", got.alu_res, exp.alu_res);
        check_value("mem_res.r_data", got.r_data, exp.r_data);
        check_value("mem_res.w_reg_ena", 32'(got.w_reg_ena), 32'(exp.w_reg_ena));
        check_value("mem_res.w_reg_dst", 32'(got.w_reg_dst), 32'(exp.w_reg_dst));
        check_value("mem_res.wb_reg_sel", 32'(got.wb_reg_sel), 32'(exp.wb_reg_sel));
        check_value("mem_res.w_hilo_ena", 32'(got.w_hilo_ena), 32'(exp.w_hilo_ena));
        check_value("mem_res.hi_res", got.hi_res, exp.hi_res);
        check_value("mem_res.lo_res", got.lo_res, exp.lo_res);
    endtask

    // nothing issued has reached the output yet
    task automatic check_reset_output();
        check_value("mem_res.w_reg_ena", 32'(mem_res.w_reg_ena), 32'h0);
        check_value("mem_res.w_hilo_ena", 32'(mem_res.w_hilo_ena), 32'h0);
        check_value("mem_res.r_data", mem_res.r_data, 32'h0);
    endtask

    // random fields, address always inside the window
    function automatic ex_req_t random_request();
        ex_req_t r;
        r.pc         = $urandom();
        r.rt_data    = $urandom();
        r.ls_ena     = ($urandom_range(0, 7) != 0);
        // 0 and 13..15 are unused codes
        r.ls_sel     = 4'($urandom_range(0, 15));
        r.w_reg_ena  = 1'($urandom_range(0, 1));
        r.w_reg_dst  = 5'($urandom_range(0, 31));
        r.wb_reg_sel = 1'($urandom_range(0, 1));
        r.w_hilo_ena = 2'($urandom_range(0, 3));
        r.hi_res     = $urandom();
        r.lo_res     = $urandom();
        r.alu_res    = WIN_BASE + 4 * $urandom_range(0, WIN_WORDS - 1)
                       + $urandom_range(0, 3);
        return r;
    endfunction

    // one op per cycle, result two edges later
    task automatic issue_op(input ex_req_t req);
        mem_res_t exp;
        @(posedge clk);
        ex_req <= req;
        predict_result(req);
        // sample away from the rising edge
        @(negedge clk);
        if (expected_q.size() > 2) begin
            exp = expected_q.pop_front();
            compare_result(mem_res, exp);
        end else begin
            check_reset_output();
        end
    endtask

    initial begin
        ex_req_t req;
        clk    = 1'b0;
        rst_n  = 1'b0;
        checks = 0;
        errors = 0;
        void'($urandom(SEED));
        // busy load with every qualifier set while reset is held
        ex_req            = random_request();
        ex_req.ls_ena     = 1'b1;
        ex_req.ls_sel     = `LS_SEL_LW;
        ex_req.w_reg_ena  = 1'b1;
        ex_req.w_hilo_ena = 2'b11;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            // let go on the third reset edge, idle from then on
            if (i == 2) begin
                rst_n  <= 1'b1;
                ex_req <= '0;
            end
            @(negedge clk);
            check_reset_output();
        end

        // fill the window so every shadow byte is defined
        for (int i = 0; i < WIN_WORDS; i++) begin
            req         = random_request();
            req.ls_ena  = 1'b1;
            req.ls_sel  = `LS_SEL_SW;
            req.alu_res = WIN_BASE + 4 * i;
            issue_op(req);
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            issue_op(random_request());
        end

        // flush the last real ops out
        for (int i = 0; i < 2; i++) begin
            req        = random_request();
            req.ls_ena = 1'b0;
            issue_op(req);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // stops a stuck run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, stimulus did not complete", WATCHDOG_NS);
        $display("checks %0d, errors %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

`include "mem_params.svh"

package lsu_pkg;

    // one operation handed over by execute
    typedef struct packed {
        logic [31:0]            pc;
        // effective address for loads and stores
        logic [31:0]            alu_res;
        logic [`MEM_DATA_W-1:0] rt_data;
        logic                   ls_ena;
        logic [3:0]             ls_sel;
        logic                   w_reg_ena;
        logic [4:0]             w_reg_dst;
        logic                   wb_reg_sel;
        // hi and lo write enables
        logic [1:0]             w_hilo_ena;
        logic [`MEM_DATA_W-1:0] hi_res;
        logic [`MEM_DATA_W-1:0] lo_res;
    } ex_req_t;

    // one access to the data ram
    typedef struct packed {
        logic                   en;
        logic [3:0]             wen;
        // byte address
        logic [31:0]            addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } ram_req_t;

    // bundle sent on to write-back
    typedef struct packed {
        logic [31:0]            pc;
        logic [31:0]            alu_res;
        logic [`MEM_DATA_W-1:0] r_data;
        logic                   w_reg_ena;
        logic [4:0]             w_reg_dst;
        logic                   wb_reg_sel;
        logic [1:0]             w_hilo_ena;
        logic [`MEM_DATA_W-1:0] hi_res;
        logic [`MEM_DATA_W-1:0] lo_res;
    } mem_res_t;

    // one data word as byte lanes or as halfwords
    typedef union packed {
        logic [`MEM_DATA_W/8-1:0][7:0]   b;
        logic [`MEM_DATA_W/16-1:0][15:0] h;
    } data_word_u;

endpackage

`default_nettype wire

//--- common/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data path width
`define MEM_DATA_W 32

// word address bits of the data ram, 1024 words by default
`define MEM_ADDR_W 10

// store select codes
`define LS_SEL_SB  4'd1
`define LS_SEL_SH  4'd2
`define LS_SEL_SW  4'd3
`define LS_SEL_SWL 4'd4
`define LS_SEL_SWR 4'd5

// load select codes, 0 and 13..15 unused
`define LS_SEL_LB  4'd6
`define LS_SEL_LBU 4'd7
`define LS_SEL_LH  4'd8
`define LS_SEL_LHU 4'd9
`define LS_SEL_LW  4'd10
`define LS_SEL_LWL 4'd11
`define LS_SEL_LWR 4'd12

`endif

//--- lsu/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// memory side of the load/store unit
// picks bytes or halves out of the read word, extends or merges them,
// then registers the write-back bundle
module lsu_load_align
    import lsu_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire ex_req_t          ex_mem,
    input  wire [`MEM_DATA_W-1:0] rdata,
    output mem_res_t              mem_res
);

    data_word_u             rd;
    logic [1:0]             off;
    logic [`MEM_DATA_W-1:0] rt;
    logic [`MEM_DATA_W-1:0] r_data;

    assign rd  = rdata;
    assign off = ex_mem.alu_res[1:0];
    assign rt  = ex_mem.rt_data;

    always_comb begin
        r_data = '0;
        // idle cycles and non-load codes give zero
        if (ex_mem.ls_ena) begin
            case (ex_mem.ls_sel)
                `LS_SEL_LB:  r_data = {{24{rd.b[off][7]}}, rd.b[off]};
                `LS_SEL_LBU: r_data = {24'h0, rd.b[off]};
                `LS_SEL_LH: begin
                    // half at offset 0 or 2 only
                    if (!off[0]) begin
                        r_data = {{16{rd.h[off[1]][15]}}, rd.h[off[1]]};
                    end
                end
                `LS_SEL_LHU: begin
                    if (!off[0]) begin
                        r_data = {16'h0, rd.h[off[1]]};
                    end
                end
                `LS_SEL_LW:  r_data = rdata;
                `LS_SEL_LWL: begin
                    // low memory bytes go to the top, rt fills below
                    case (off)
                        2'd0:    r_data = {rd.b[0], rt[23:0]};
                        2'd1:    r_data = {rd.h[0], rt[15:0]};
                        2'd2:    r_data = {rd.b[2], rd.b[1], rd.b[0], rt[7:0]};
                        default: r_data = rdata;
                    endcase
                end
                `LS_SEL_LWR: begin
                    // high memory bytes go to the bottom, rt keeps the top
                    case (off)
                        2'd0:    r_data = rdata;
                        2'd1:    r_data = {rt[31:24], rd.b[3], rd.b[2], rd.b[1]};
                        2'd2:    r_data = {rt[31:16], rd.h[1]};
                        default: r_data = {rt[31:8], rd.b[3]};
                    endcase
                end
                default: r_data = '0;
            endcase
        end
    end

    // output register toward write-back
    always_ff @(posedge clk) begin
        // pass-through payload
        mem_res.pc         <= ex_mem.pc;
        mem_res.alu_res    <= ex_mem.alu_res;
        mem_res.w_reg_dst  <= ex_mem.w_reg_dst;
        mem_res.wb_reg_sel <= ex_mem.wb_reg_sel;
        mem_res.hi_res     <= ex_mem.hi_res;
        mem_res.lo_res     <= ex_mem.lo_res;
        if (!rst_n) begin
            mem_res.w_reg_ena  <= 1'b0;
            mem_res.w_hilo_ena <= 2'b00;
            mem_res.r_data     <= '0;
        end else begin
            mem_res.w_reg_ena  <= ex_mem.w_reg_ena;
            mem_res.w_hilo_ena <= ex_mem.w_hilo_ena;
            mem_res.r_data     <= r_data;
        end
    end

endmodule

`default_nettype wire

//--- lsu/lsu_store_fmt.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// execute side of the load/store unit
// builds the ram strobe, byte enables and lane-positioned store data
module lsu_store_fmt
    import lsu_pkg::*;
(
    input  wire ex_req_t ex_req,
    output ram_req_t     ram_req
);

    // byte offset inside the word
    logic [1:0]             off;
    logic [`MEM_DATA_W-1:0] rt;
    logic [3:0]             wen;
    data_word_u             wd;

    assign off = ex_req.alu_res[1:0];
    assign rt  = ex_req.rt_data;

    always_comb begin
        wen = 4'b0000;
        wd  = '0;
        case (ex_req.ls_sel)
            `LS_SEL_SB: begin
                // only the addressed lane
                wen[off] = 1'b1;
                wd.b     = {4{rt[7:0]}};
            end
            `LS_SEL_SH: begin
                // odd offsets write nothing, no exception raised
                if (off[0]) begin
                    wen = 4'b0000;
                end else if (off[1]) begin
                    wen = 4'b1100;
                end else begin
                    wen = 4'b0011;
                end
                wd.b = {2{rt[15:0]}};
            end
            `LS_SEL_SW: begin
                wen = 4'b1111;
                wd  = rt;
            end
            `LS_SEL_SWL: begin
                // offset k keeps lanes 0..k
                wen = 4'b1111 >> (2'd3 - off);
                // high bytes of rt slide down into those lanes
                wd  = rt >> (8 * (2'd3 - off));
            end
            `LS_SEL_SWR: begin
                // offset k keeps lanes k..3
                wen = 4'b1111 << off;
                // low bytes of rt slide up
                wd  = rt << (8 * off);
            end
            default: begin
                // loads and unused codes only read
                wen = 4'b0000;
                wd  = '0;
            end
        endcase
    end

    // strobe follows the enable level directly
    always_comb begin
        ram_req.en    = ex_req.ls_ena;
        ram_req.wen   = ex_req.ls_ena ? wen : 4'b0000;
        // address zeroed when idle
        ram_req.addr  = ex_req.ls_ena ? ex_req.alu_res : 32'h0;
        ram_req.wdata = wd;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
+incdir+bench
common/lsu_pkg.sv
lsu/lsu_store_fmt.sv
lsu/lsu_load_align.sv
src/data_ram.sv
src/ex_mem_reg.sv
src/mem_stage_top.sv
bench/tb_mem_stage.sv

//--- src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// single-port data ram
// byte lane writes, registered read with one cycle latency
module data_ram
    import lsu_pkg::*;
(
    input  wire                    clk,
    input  wire ram_req_t          ram_req,
    output logic [`MEM_DATA_W-1:0] rdata
);

    // word storage, contents undefined after power-up
    logic [`MEM_DATA_W-1:0] mem [0:(1 << `MEM_ADDR_W)-1];
    // word index above the byte offset
    logic [`MEM_ADDR_W-1:0] idx;

    assign idx = ram_req.addr[`MEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            // each enabled lane on its own
            for (int i = 0; i < `MEM_DATA_W / 8; i++) begin
                if (ram_req.wen[i]) begin
                    mem[idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
            // old contents on a same-edge write, fine since an op
            // never reads and writes at once
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- src/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

// ex/mem boundary
// holds the request for the cycle the ram read word comes back
module ex_mem_reg
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire ex_req_t ex_req,
    output ex_req_t      ex_mem
);

    always_ff @(posedge clk) begin
        // whole request every edge
        ex_mem <= ex_req;
        // reset only kills the qualifiers
        if (!rst_n) begin
            ex_mem.ls_ena     <= 1'b0;
            ex_mem.w_reg_ena  <= 1'b0;
            ex_mem.w_hilo_ena <= 2'b00;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// memory-access stage
// ex_req before edge t shows up on mem_res after edge t+1
module mem_stage_top
    import lsu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire ex_req_t ex_req,
    output mem_res_t     mem_res
);

    // combinational from ex_req
    ram_req_t               ram_req;
    // read word, one edge behind ram_req
    logic [`MEM_DATA_W-1:0] rdata;
    // request aligned with rdata
    ex_req_t                ex_mem;

    lsu_store_fmt u_store_fmt (
        .ex_req  (ex_req),
        .ram_req (ram_req)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_req (ex_req),
        .ex_mem (ex_mem)
    );

    // load side plus output register
    lsu_load_align u_load_align (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_mem  (ex_mem),
        .rdata   (rdata),
        .mem_res (mem_res)
    );

endmodule

`default_nettype wire
